// ==== compile.f ====
axi_ic_pkg.sv
axi_master_arbiter_w.sv
axi_master_mux_w.sv
axi_slave_mux_w.sv
axi_ic_w_top.sv
axi_ic_w_tb.sv

// ==== axi_ic_w_tb.sv ====
/* directed testbench for the AXI4 write interconnect: two master drivers, four
   slave models with random ready delays, and one task per tested behavior */
`default_nettype none

module axi_ic_w_tb;

    import axi_ic_pkg::*;

    localparam int WAIT_LIMIT = 100;

    logic                        ACLK;
    logic                        ARESETn;
    aw_chan_t [NUM_MASTERS-1:0]  m_aw;
    logic     [NUM_MASTERS-1:0]  m_awvalid;
    logic     [NUM_MASTERS-1:0]  m_awready;
    w_chan_t  [NUM_MASTERS-1:0]  m_w;
    logic     [NUM_MASTERS-1:0]  m_wvalid;
    logic     [NUM_MASTERS-1:0]  m_wready;
    b_chan_t  [NUM_MASTERS-1:0]  m_b;
    logic     [NUM_MASTERS-1:0]  m_bvalid;
    logic     [NUM_MASTERS-1:0]  m_bready;
    aw_chan_t [NUM_SLAVES-1:0]   s_aw;
    logic     [NUM_SLAVES-1:0]   s_awvalid;
    logic     [NUM_SLAVES-1:0]   s_awready;
    w_chan_t  [NUM_SLAVES-1:0]   s_w;
    logic     [NUM_SLAVES-1:0]   s_wvalid;
    logic     [NUM_SLAVES-1:0]   s_wready;
    b_chan_t  [NUM_SLAVES-1:0]   s_b;
    logic     [NUM_SLAVES-1:0]   s_bvalid;
    logic     [NUM_SLAVES-1:0]   s_bready;

    // --------------------
    // slave model state, 0 address, 1 data, 2 response
    int       phase [NUM_SLAVES];
    int       delay [NUM_SLAVES];
    int       beat_no [NUM_SLAVES];
    aw_chan_t cur_aw [NUM_SLAVES];
    // what each slave received, in order
    aw_chan_t aw_log [NUM_SLAVES][$];
    w_chan_t  w_log [NUM_SLAVES][$];
    id_t      aw_order [$];
    // slave memory keyed by slave index and byte address
    data_t    mem [logic [SEL_WIDTH+ADDR_WIDTH-1:0]];
    int       b_count [NUM_MASTERS];
    int       max_delay;
    resp_t    slave_resp;
    // expected owner and target, -1 turns the bus watch off
    int       exp_mst;
    int       exp_slv;

    axi_ic_w_top i_dut (.*);

    initial begin
        ACLK = 1'b0;
        forever #5 ACLK = ~ACLK;
    end

    task automatic stop_with_error(input string why);
        $display("ERROR: %s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // --------------------
    // slave responder, one step per clock edge
    task automatic step_slave(input int s);
        case (phase[s])
            0: begin
                if (s_awvalid[s] && s_awready[s]) begin
                    cur_aw[s] = s_aw[s];
                    aw_log[s].push_back(s_aw[s]);
                    aw_order.push_back(s_aw[s].id);
                    s_awready[s] <= 1'b0;
                    delay[s] = $urandom_range(0, max_delay);
                    beat_no[s] = 0;
                    phase[s] = 1;
                end else if (s_awvalid[s]) begin
                    if (delay[s] == 0) s_awready[s] <= 1'b1;
                    else delay[s] = delay[s] - 1;
                end
            end
            1: begin
                if (s_wvalid[s] && s_wready[s]) begin
                    w_log[s].push_back(s_w[s]);
                    mem[{slv_idx_t'(s), cur_aw[s].addr + addr_t'(beat_no[s] * STRB_WIDTH)}]
                        = s_w[s].data;
                    beat_no[s] = beat_no[s] + 1;
                    s_wready[s] <= 1'b0;
                    delay[s] = $urandom_range(0, max_delay);
                    // response right after the last beat
                    if (s_w[s].last) begin
                        s_b[s].id   <= cur_aw[s].id;
                        s_b[s].resp <= slave_resp;
                        s_bvalid[s] <= 1'b1;
                        phase[s] = 2;
                    end
                end else if (s_wvalid[s]) begin
                    if (delay[s] == 0) s_wready[s] <= 1'b1;
                    else delay[s] = delay[s] - 1;
                end
            end
            default: begin
                if (s_bvalid[s] && s_bready[s]) begin
                    s_bvalid[s] <= 1'b0;
                    phase[s] = 0;
                end
            end
        endcase
    endtask

    // bus isolation of idle masters and unaddressed slaves
    task automatic watch_bus();
        int other;
        // every cycle with a B on offer counts, taken or not
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (m_bvalid[m]) b_count[m] = b_count[m] + 1;
        end
        if (exp_mst >= 0) begin
            other = 1 - exp_mst;
            check_val($sformatf("m_awready[%0d]", other), m_awready[other], 0);
            check_val($sformatf("m_wready[%0d]", other), m_wready[other], 0);
            check_val($sformatf("m_bvalid[%0d]", other), m_bvalid[other], 0);
        end
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (exp_slv >= 0 && s != exp_slv) begin
                check_val($sformatf("s_awvalid[%0d]", s), s_awvalid[s], 0);
                check_val($sformatf("s_wvalid[%0d]", s), s_wvalid[s], 0);
            end
        end
    endtask

    initial begin
        forever begin
            @(posedge ACLK);
            if (ARESETn) begin
                watch_bus();
                for (int s = 0; s < NUM_SLAVES; s++) step_slave(s);
            end
        end
    end

    task automatic reset_dut();
        @(posedge ACLK);
        ARESETn   <= 1'b0;
        m_awvalid <= '0;
        m_wvalid  <= '0;
        m_bready  <= '0;
        s_awready <= '0;
        s_wready  <= '0;
        s_bvalid  <= '0;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            phase[s] = 0;
            delay[s] = 0;
            aw_log[s].delete();
            w_log[s].delete();
        end
        aw_order.delete();
        repeat (16) @(posedge ACLK);
        ARESETn <= 1'b1;
    endtask

    // --------------------
    // master driver: one INCR burst, then B and the slave-side record are checked
    task automatic write_burst(input int m, input addr_t start_addr, input id_t txn_id,
                               input int nbeats, input resp_t exp_resp,
                               output data_t first_word);
        aw_chan_t aw;
        aw_chan_t got_aw;
        w_chan_t  beats [$];
        w_chan_t  beat;
        w_chan_t  got_w;
        b_chan_t  b;
        int       s;
        int       n;
        aw.addr  = start_addr;
        aw.id    = txn_id;
        aw.len   = len_t'(nbeats - 1);
        aw.size  = 3'd2;
        aw.burst = 2'b01;
        // target slave from the top address bits
        s = int'(start_addr[SEL_LSB +: SEL_WIDTH]);
        for (int i = 0; i < nbeats; i++) begin
            beat.data = $urandom;
            beat.strb = strb_t'($urandom_range(1, 15));
            beat.last = (i == nbeats - 1);
            beats.push_back(beat);
        end
        first_word = beats[0].data;
        m_aw[m]      <= aw;
        m_awvalid[m] <= 1'b1;
        n = 0;
        do begin
            @(posedge ACLK);
            n++;
            if (n > WAIT_LIMIT) stop_with_error("timeout waiting for AWREADY");
        end while (!m_awready[m]);
        m_awvalid[m] <= 1'b0;
        for (int i = 0; i < nbeats; i++) begin
            m_w[m]      <= beats[i];
            m_wvalid[m] <= 1'b1;
            n = 0;
            do begin
                @(posedge ACLK);
                n++;
                if (n > WAIT_LIMIT) stop_with_error("timeout waiting for WREADY");
            end while (!m_wready[m]);
        end
        m_wvalid[m] <= 1'b0;
        m_bready[m] <= 1'b1;
        n = 0;
        do begin
            @(posedge ACLK);
            n++;
            if (n > WAIT_LIMIT) stop_with_error("timeout waiting for BVALID");
        end while (!m_bvalid[m]);
        b = m_b[m];
        m_bready[m] <= 1'b0;
        check_val("m_b.id", b.id, txn_id);
        check_val("m_b.resp", b.resp, exp_resp);
        // address and beats as seen by the addressed slave
        if (aw_log[s].size() == 0) stop_with_error("address never reached its slave");
        got_aw = aw_log[s].pop_front();
        check_val("s_aw.addr", got_aw.addr, start_addr);
        check_val("s_aw.id", got_aw.id, txn_id);
        check_val("s_aw.len", got_aw.len, nbeats - 1);
        foreach (beats[i]) begin
            if (w_log[s].size() == 0) stop_with_error("write beat missing at slave");
            got_w = w_log[s].pop_front();
            check_val("s_w.data", got_w.data, beats[i].data);
            check_val("s_w.strb", got_w.strb, beats[i].strb);
            check_val("s_w.last", got_w.last, beats[i].last);
        end
    endtask

    task automatic check_logs_empty();
        for (int s = 0; s < NUM_SLAVES; s++) begin
            check_val($sformatf("aw_log[%0d] size", s), aw_log[s].size(), 0);
            check_val($sformatf("w_log[%0d] size", s), w_log[s].size(), 0);
        end
    endtask

    // --------------------
    // directed tests
    task automatic test_single();
        data_t word;
        exp_mst = 0;
        exp_slv = 0;
        write_burst(0, 32'h0000_0010, 4'h3, 1, RESP_OKAY, word);
        check_val("slave 0 memory entry", mem.exists({2'd0, 32'h0000_0010}), 1);
        check_val("slave 0 mem[0x10]", mem[{2'd0, 32'h0000_0010}], word);
    endtask

    task automatic test_decode();
        data_t word;
        for (int r = 0; r < NUM_SLAVES; r++) begin
            exp_slv = r;
            write_burst(0, {slv_idx_t'(r), 30'h0000_0100}, id_t'(r), 2, RESP_OKAY, word);
        end
        check_logs_empty();
    endtask

    task automatic test_burst();
        data_t word;
        int    b_before;
        exp_slv  = 1;
        b_before = b_count[0];
        write_burst(0, 32'h4000_0040, 4'h5, 4, RESP_OKAY, word);
        repeat (8) @(posedge ACLK);
        check_val("B responses for one burst", b_count[0] - b_before, 1);
        check_logs_empty();
    endtask

    // both masters keep requesting, owners must take turns
    task automatic test_alternate();
        data_t word0;
        data_t word1;
        reset_dut();
        exp_mst = -1;
        exp_slv = -1;
        fork
            for (int k = 0; k < 3; k++) begin
                write_burst(0, 32'h4000_0100 + 16 * k, id_t'(k), 2, RESP_OKAY, word0);
            end
            for (int k = 0; k < 3; k++) begin
                write_burst(1, 32'h8000_0200 + 16 * k, id_t'(8 + k), 2, RESP_OKAY, word1);
            end
        join
        check_val("AW count", aw_order.size(), 6);
        foreach (aw_order[i]) begin
            check_val($sformatf("owner of AW %0d", i), aw_order[i][3], i % 2);
        end
        check_logs_empty();
    endtask

    task automatic test_backpressure();
        data_t word;
        max_delay = 7;
        exp_mst   = 1;
        for (int k = 0; k < 3; k++) begin
            exp_slv = k + 1;
            write_burst(1, {slv_idx_t'(k + 1), 30'h0000_0300}, id_t'(k + 4), 4,
                        RESP_OKAY, word);
        end
        check_logs_empty();
        max_delay = 3;
    endtask

    task automatic test_error_resp();
        data_t word;
        int    b_other;
        slave_resp = 2'b10;
        exp_mst    = 1;
        exp_slv    = 3;
        b_other    = b_count[0];
        write_burst(1, 32'hC000_0080, 4'hA, 2, 2'b10, word);
        repeat (4) @(posedge ACLK);
        check_val("B responses at master 0", b_count[0] - b_other, 0);
        slave_resp = RESP_OKAY;
    endtask

    initial begin
        void'($urandom(28269));
        ARESETn   <= 1'b0;
        m_aw      <= '0;
        m_awvalid <= '0;
        m_w       <= '0;
        m_wvalid  <= '0;
        m_bready  <= '0;
        s_awready <= '0;
        s_wready  <= '0;
        s_b       <= '0;
        s_bvalid  <= '0;
        max_delay  = 3;
        slave_resp = RESP_OKAY;
        exp_mst    = -1;
        exp_slv    = -1;
        b_count[0] = 0;
        b_count[1] = 0;
        reset_dut();
        test_single();
        test_decode();
        test_burst();
        test_alternate();
        test_backpressure();
        test_error_resp();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== axi_ic_w_top.sv ====
/* top of the AXI4 write interconnect, two masters onto four slaves;
   holds the arbiter, both multiplexers and the shared bus between them */
`default_nettype none

module axi_ic_w_top (
    input  logic                                               ACLK,
    input  logic                                               ARESETn,

    // --------------------
    // master ports
    input  axi_ic_pkg::aw_chan_t [axi_ic_pkg::NUM_MASTERS-1:0] m_aw,
    input  logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_awvalid,
    output logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_awready,
    input  axi_ic_pkg::w_chan_t  [axi_ic_pkg::NUM_MASTERS-1:0] m_w,
    input  logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_wvalid,
    output logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_wready,
    output axi_ic_pkg::b_chan_t  [axi_ic_pkg::NUM_MASTERS-1:0] m_b,
    output logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_bvalid,
    input  logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_bready,

    // --------------------
    // slave ports
    output axi_ic_pkg::aw_chan_t [axi_ic_pkg::NUM_SLAVES-1:0]  s_aw,
    output logic                 [axi_ic_pkg::NUM_SLAVES-1:0]  s_awvalid,
    input  logic                 [axi_ic_pkg::NUM_SLAVES-1:0]  s_awready,
    output axi_ic_pkg::w_chan_t  [axi_ic_pkg::NUM_SLAVES-1:0]  s_w,
    output logic                 [axi_ic_pkg::NUM_SLAVES-1:0]  s_wvalid,
    input  logic                 [axi_ic_pkg::NUM_SLAVES-1:0]  s_wready,
    input  axi_ic_pkg::b_chan_t  [axi_ic_pkg::NUM_SLAVES-1:0]  s_b,
    input  logic                 [axi_ic_pkg::NUM_SLAVES-1:0]  s_bvalid,
    output logic                 [axi_ic_pkg::NUM_SLAVES-1:0]  s_bready
);

    import axi_ic_pkg::*;

    // arbiter result
    logic     grant_valid;
    mst_idx_t grant_idx;

    // shared write bus between the two muxes
    aw_chan_t bus_aw;
    logic     bus_awvalid;
    logic     bus_awready;
    w_chan_t  bus_w;
    logic     bus_wvalid;
    logic     bus_wready;
    b_chan_t  bus_b;
    logic     bus_bvalid;
    logic     bus_bready;

    // bus ownership, released on the B handshake
    axi_master_arbiter_w i_arbiter (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .m_awvalid   (m_awvalid),
        .bus_bvalid  (bus_bvalid),
        .bus_bready  (bus_bready),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx)
    );

    // granted master onto the bus
    axi_master_mux_w i_master_mux (
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .m_aw        (m_aw),
        .m_awvalid   (m_awvalid),
        .m_awready   (m_awready),
        .m_w         (m_w),
        .m_wvalid    (m_wvalid),
        .m_wready    (m_wready),
        .m_b         (m_b),
        .m_bvalid    (m_bvalid),
        .m_bready    (m_bready),
        .bus_aw      (bus_aw),
        .bus_awvalid (bus_awvalid),
        .bus_awready (bus_awready),
        .bus_w       (bus_w),
        .bus_wvalid  (bus_wvalid),
        .bus_wready  (bus_wready),
        .bus_b       (bus_b),
        .bus_bvalid  (bus_bvalid),
        .bus_bready  (bus_bready)
    );

    // bus onto the addressed slave
    axi_slave_mux_w i_slave_mux (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .bus_aw      (bus_aw),
        .bus_awvalid (bus_awvalid),
        .bus_awready (bus_awready),
        .bus_w       (bus_w),
        .bus_wvalid  (bus_wvalid),
        .bus_wready  (bus_wready),
        .bus_b       (bus_b),
        .bus_bvalid  (bus_bvalid),
        .bus_bready  (bus_bready),
        .s_aw        (s_aw),
        .s_awvalid   (s_awvalid),
        .s_awready   (s_awready),
        .s_w         (s_w),
        .s_wvalid    (s_wvalid),
        .s_wready    (s_wready),
        .s_b         (s_b),
        .s_bvalid    (s_bvalid),
        .s_bready    (s_bready)
    );

endmodule

`default_nettype wire

// ==== axi_slave_mux_w.sv ====
/* slave-side multiplexer: decodes the slave from the top AWADDR bits, keeps the
   address at the AW handshake and steers W and B to that slave until the response */
`default_nettype none

module axi_slave_mux_w (
    input  logic                                              ACLK,
    input  logic                                              ARESETn,

    // shared bus side
    input  axi_ic_pkg::aw_chan_t                              bus_aw,
    input  logic                                              bus_awvalid,
    output logic                                              bus_awready,
    input  axi_ic_pkg::w_chan_t                               bus_w,
    input  logic                                              bus_wvalid,
    output logic                                              bus_wready,
    output axi_ic_pkg::b_chan_t                               bus_b,
    output logic                                              bus_bvalid,
    input  logic                                              bus_bready,

    // slave side
    output axi_ic_pkg::aw_chan_t [axi_ic_pkg::NUM_SLAVES-1:0] s_aw,
    output logic                 [axi_ic_pkg::NUM_SLAVES-1:0] s_awvalid,
    input  logic                 [axi_ic_pkg::NUM_SLAVES-1:0] s_awready,
    output axi_ic_pkg::w_chan_t  [axi_ic_pkg::NUM_SLAVES-1:0] s_w,
    output logic                 [axi_ic_pkg::NUM_SLAVES-1:0] s_wvalid,
    input  logic                 [axi_ic_pkg::NUM_SLAVES-1:0] s_wready,
    input  axi_ic_pkg::b_chan_t  [axi_ic_pkg::NUM_SLAVES-1:0] s_b,
    input  logic                 [axi_ic_pkg::NUM_SLAVES-1:0] s_bvalid,
    output logic                 [axi_ic_pkg::NUM_SLAVES-1:0] s_bready
);

    import axi_ic_pkg::*;

    route_state_e state_q;
    // address captured at the AW handshake
    addr_t        awaddr_q;
    slv_idx_t     aw_sel;
    slv_idx_t     cur_sel;
    logic         aw_done;
    logic         w_last_done;
    logic         b_done;

    // live decode for AW, stored decode for W and B
    assign aw_sel  = bus_aw.addr[SEL_LSB +: SEL_WIDTH];
    assign cur_sel = awaddr_q[SEL_LSB +: SEL_WIDTH];

    assign aw_done     = bus_awvalid & bus_awready;
    assign w_last_done = bus_wvalid & bus_wready & bus_w.last;
    assign b_done      = bus_bvalid & bus_bready;

    // --------------------
    // route state and address register
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q  <= ROUTE_IDLE;
            awaddr_q <= '0;
        end else begin
            case (state_q)
                ROUTE_IDLE: begin
                    if (aw_done) begin
                        awaddr_q <= bus_aw.addr;
                        state_q  <= ROUTE_DATA;
                    end
                end
                // stays here across all beats of a burst
                ROUTE_DATA: if (w_last_done) state_q <= ROUTE_RESP;
                ROUTE_RESP: if (b_done) state_q <= ROUTE_IDLE;
                default:    state_q <= ROUTE_IDLE;
            endcase
        end
    end

    // --------------------
    // steering of valid, ready and response
    always_comb begin
        s_awvalid   = '0;
        s_wvalid    = '0;
        s_bready    = '0;
        bus_awready = 1'b0;
        bus_wready  = 1'b0;
        bus_bvalid  = 1'b0;
        bus_b       = '0;

        // payloads go to every slave, valid picks the one
        for (int s = 0; s < NUM_SLAVES; s++) begin
            s_aw[s] = bus_aw;
            s_w[s]  = bus_w;
        end

        case (state_q)
            ROUTE_IDLE: begin
                s_awvalid[aw_sel] = bus_awvalid;
                bus_awready       = s_awready[aw_sel];
            end
            ROUTE_DATA: begin
                s_wvalid[cur_sel] = bus_wvalid;
                bus_wready        = s_wready[cur_sel];
            end
            ROUTE_RESP: begin
                s_bready[cur_sel] = bus_bready;
                bus_bvalid        = s_bvalid[cur_sel];
                bus_b             = s_b[cur_sel];
            end
            default: ;
        endcase
    end

    // --------------------
    // W beats never show up before their AW or after WLAST
    a_wvalid_in_data: assert property (@(posedge ACLK) disable iff (!ARESETn)
        bus_wvalid |-> (state_q == ROUTE_DATA))
        else $error("W offered outside the data phase");

    // an unaccepted address stays on the one slave it was decoded for
    a_awvalid_held: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (|s_awvalid) && !(|(s_awvalid & s_awready)) |=> $stable(s_awvalid))
        else $error("AWVALID moved or dropped before the slave accepted it");

endmodule

`default_nettype wire

// ==== axi_master_mux_w.sv ====
/* master-side multiplexer: puts the granted master's AW and W on the shared bus
   and returns ready signals and the B response to that master alone */
`default_nettype none

module axi_master_mux_w (
    input  logic                                               grant_valid,
    input  axi_ic_pkg::mst_idx_t                               grant_idx,

    // master side
    input  axi_ic_pkg::aw_chan_t [axi_ic_pkg::NUM_MASTERS-1:0] m_aw,
    input  logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_awvalid,
    output logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_awready,
    input  axi_ic_pkg::w_chan_t  [axi_ic_pkg::NUM_MASTERS-1:0] m_w,
    input  logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_wvalid,
    output logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_wready,
    output axi_ic_pkg::b_chan_t  [axi_ic_pkg::NUM_MASTERS-1:0] m_b,
    output logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_bvalid,
    input  logic                 [axi_ic_pkg::NUM_MASTERS-1:0] m_bready,

    // shared bus side
    output axi_ic_pkg::aw_chan_t                               bus_aw,
    output logic                                               bus_awvalid,
    input  logic                                               bus_awready,
    output axi_ic_pkg::w_chan_t                                bus_w,
    output logic                                               bus_wvalid,
    input  logic                                               bus_wready,
    input  axi_ic_pkg::b_chan_t                                bus_b,
    input  logic                                               bus_bvalid,
    output logic                                               bus_bready
);

    import axi_ic_pkg::*;

    // --------------------
    // forward path, master to bus
    always_comb begin
        // payloads follow the index even without a grant
        bus_aw = m_aw[grant_idx];
        bus_w  = m_w[grant_idx];

        // valids and BREADY only count under a grant
        bus_awvalid = grant_valid & m_awvalid[grant_idx];
        bus_wvalid  = grant_valid & m_wvalid[grant_idx];
        bus_bready  = grant_valid & m_bready[grant_idx];
    end

    // --------------------
    // return path, bus to the granted master only
    always_comb begin
        // everyone sees zeros by default
        m_awready = '0;
        m_wready  = '0;
        m_bvalid  = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_b[m] = '0;
        end

        if (grant_valid) begin
            m_awready[grant_idx] = bus_awready;
            m_wready[grant_idx]  = bus_wready;
            m_bvalid[grant_idx]  = bus_bvalid;
            m_b[grant_idx]       = bus_b;
        end
    end

endmodule

`default_nettype wire

// ==== axi_master_arbiter_w.sv ====
/* rotating-priority arbiter for the shared write bus; the grant is held
   from the request until the write response handshake */
`default_nettype none

module axi_master_arbiter_w (
    input  logic                               ACLK,
    input  logic                               ARESETn,
    input  logic [axi_ic_pkg::NUM_MASTERS-1:0] m_awvalid,
    input  logic                               bus_bvalid,
    input  logic                               bus_bready,
    output logic                               grant_valid,
    output axi_ic_pkg::mst_idx_t               grant_idx
);

    import axi_ic_pkg::*;

    arb_state_e state_q;
    // master that gets first look at the next arbitration
    mst_idx_t   prio_q;
    mst_idx_t   pick_idx;
    mst_idx_t   pick_next;
    logic       pick_found;
    logic       b_done;

    // response handshake closes the transaction
    assign b_done = bus_bvalid & bus_bready;

    // --------------------
    // search from the priority pointer, wrapping around
    always_comb begin
        int cand;
        pick_idx   = prio_q;
        pick_found = 1'b0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            cand = (int'(prio_q) + i) % NUM_MASTERS;
            if (!pick_found && m_awvalid[cand]) begin
                pick_found = 1'b1;
                pick_idx   = mst_idx_t'(cand);
            end
        end
    end

    // master after the winner
    assign pick_next = mst_idx_t'((int'(pick_idx) + 1) % NUM_MASTERS);

    // --------------------
    // grant state machine
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q   <= ARB_IDLE;
            grant_idx <= '0;
            prio_q    <= '0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (pick_found) begin
                        state_q   <= ARB_BUSY;
                        grant_idx <= pick_idx;
                        prio_q    <= pick_next;
                    end
                end
                ARB_BUSY: begin
                    // back to idle one edge after B, next grant one later
                    if (b_done) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    assign grant_valid = (state_q == ARB_BUSY);

    // --------------------
    // owner is kept until its response has been taken
    a_grant_held: assert property (@(posedge ACLK) disable iff (!ARESETn)
        grant_valid && !b_done |=> grant_valid && $stable(grant_idx))
        else $error("grant dropped or changed before the B handshake");

    // winner still holds AWVALID, nobody has accepted it yet
    a_grant_to_requester: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $rose(grant_valid) |-> m_awvalid[grant_idx])
        else $error("grant given to a master without AWVALID");

endmodule

`default_nettype wire

// ==== axi_ic_pkg.sv ====
/* widths, index types and channel payload structs for the AXI4 write interconnect,
   imported by every module of the design */
`default_nettype none

package axi_ic_pkg;

    // --------------------
    // port counts
    localparam int NUM_MASTERS = 2;
    localparam int NUM_SLAVES  = 4;

    // bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH   = 4;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int LEN_WIDTH  = 8;

    // slave select field, top bits of AWADDR
    localparam int SEL_LSB   = 30;
    localparam int SEL_WIDTH = $clog2(NUM_SLAVES);

    // one bit is enough for two masters
    localparam int MST_IDX_WIDTH = $clog2(NUM_MASTERS);

    // --------------------
    // plain vectors
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [STRB_WIDTH-1:0]    strb_t;
    typedef logic [ID_WIDTH-1:0]      id_t;
    typedef logic [LEN_WIDTH-1:0]     len_t;
    typedef logic [1:0]               resp_t;
    typedef logic [MST_IDX_WIDTH-1:0] mst_idx_t;
    typedef logic [SEL_WIDTH-1:0]     slv_idx_t;

    // normal access success
    localparam resp_t RESP_OKAY = 2'b00;

    // --------------------
    // channel payloads, valid and ready travel beside them
    typedef struct packed {
        addr_t      addr;
        id_t        id;
        len_t       len;
        logic [2:0] size;
        logic [1:0] burst;
    } aw_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_chan_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_chan_t;

    // --------------------
    // state machines
    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_e;

    typedef enum logic [1:0] {
        ROUTE_IDLE,
        ROUTE_DATA,
        ROUTE_RESP
    } route_state_e;

endpackage

`default_nettype wire
